// ==== list.f ====
source/cam_pkg.sv
source/cam_sample_if.sv
source/cam_pixel_if.sv
source/cam_word_if.sv
source/cam_cdc_fifo.sv
source/frame_sync_decoder.sv
source/pixel_packer.sv
source/word_fifo.sv
source/cam_data_module.sv
testbench/tb_cam_data_module.sv

// ==== source/cam_cdc_fifo.sv ====
`timescale 1ns/1ps

module cam_cdc_fifo #(
    parameter int cdc_addr_width = 4
) (
    input  logic            pclk_i,
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            vsync_i,
    input  logic            href_i,
    input  cam_pkg::pixel_t d_i,
    cam_sample_if.src       sample_o
);

    localparam int depth = 2 ** cdc_addr_width;

    // Extra top bit tells full from empty
    typedef logic [cdc_addr_width:0] ptr_t;

    cam_pkg::sample_t mem [depth];

    // Camera clock domain
    ptr_t wr_bin;
    ptr_t wr_gray;
    ptr_t wr_bin_next;
    ptr_t rd_gray_s1;
    ptr_t rd_gray_s2;
    logic full;
    logic push;

    // System clock domain
    ptr_t rd_bin;
    ptr_t rd_gray;
    ptr_t rd_bin_next;
    ptr_t wr_gray_s1;
    ptr_t wr_gray_s2;
    logic empty;
    logic pop;

    ////////////////////////////////////////
    // Write side, pclk_i
    ////////////////////////////////////////

    // Full when write pointer is one lap ahead, top two Gray bits flipped
    assign full = (wr_gray == {~rd_gray_s2[cdc_addr_width -: 2],
                               rd_gray_s2[cdc_addr_width-2:0]});
    // Camera cannot wait, sample lost when full
    assign push = !full;
    assign wr_bin_next = wr_bin + 1'b1;

    always_ff @(posedge pclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
        end else begin
            // Read pointer into camera domain
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
            if (push) begin
                wr_bin  <= wr_bin_next;
                wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
            end
        end
    end

    // Sample captured on every camera edge
    always_ff @(posedge pclk_i) begin
        if (push) begin
            mem[wr_bin[cdc_addr_width-1:0]] <= {href_i, vsync_i, d_i};
        end
    end

    ////////////////////////////////////////
    // Read side, clk_i
    ////////////////////////////////////////

    assign empty = (rd_gray == wr_gray_s2);
    assign pop = sample_o.pop && !empty;
    assign rd_bin_next = rd_bin + 1'b1;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
        end else begin
            // Write pointer into system domain
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
            if (pop) begin
                rd_bin  <= rd_bin_next;
                rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
            end
        end
    end

    // Head sample shown directly
    assign sample_o.sample = mem[rd_bin[cdc_addr_width-1:0]];
    assign sample_o.empty  = empty;

endmodule

// ==== source/cam_data_module.sv ====
`timescale 1ns/1ps

module cam_data_module #(
    parameter int cdc_addr_width  = 4,
    parameter int word_addr_width = 3
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 wb_stb_i,
    // Camera side
    input  logic                 pclk_i,
    input  logic                 vsync_i,
    input  logic                 href_i,
    input  cam_pkg::pixel_t      d_i,
    // Bus side
    output cam_pkg::word_t       wb_dat_o,
    output logic                 wb_ack_o,
    output logic                 wb_rty_o,
    output logic                 irq_new_frame_o,
    output logic                 buffer_fifo_full_o,
    output cam_pkg::first_word_t out_first_word_o
);

    cam_sample_if sample_if ();
    cam_pixel_if  pixel_if ();
    cam_word_if   word_if ();

    // pclk_i to clk_i crossing
    cam_cdc_fifo #(
        .cdc_addr_width(cdc_addr_width)
    ) cam_cdc_fifo_i (
        .pclk_i(pclk_i), .clk_i(clk_i), .rst_n_i(rst_n_i),
        .vsync_i(vsync_i), .href_i(href_i), .d_i(d_i),
        .sample_o(sample_if.src)
    );

    // Sync levels to events
    frame_sync_decoder frame_sync_decoder_i (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .sample_i(sample_if.dst), .pixel_o(pixel_if.src),
        .irq_new_frame_o(irq_new_frame_o)
    );

    // Four pixels per word
    pixel_packer pixel_packer_i (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .pixel_i(pixel_if.dst), .word_o(word_if.src)
    );

    word_fifo #(
        .word_addr_width(word_addr_width)
    ) word_fifo_i (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .word_i(word_if.dst), .wb_stb_i(wb_stb_i),
        .wb_dat_o(wb_dat_o), .out_first_word_o(out_first_word_o), .wb_ack_o(wb_ack_o),
        .wb_rty_o(wb_rty_o), .buffer_fifo_full_o(buffer_fifo_full_o)
    );

endmodule

// ==== source/cam_pixel_if.sv ====
`timescale 1ns/1ps

// Decoded pixel stream with frame and line events
interface cam_pixel_if;

    cam_pkg::pixel_t pixel;
    // One strobe per active pixel
    logic pixel_valid;
    // Single-cycle event pulses
    logic frame_start;
    logic line_start;
    // Packer holds a finished word, stop popping
    logic stall;

    modport src (output pixel, output pixel_valid, output frame_start, output line_start,
                 input stall);
    modport dst (input pixel, input pixel_valid, input frame_start, input line_start,
                 output stall);

endinterface

// ==== source/cam_pkg.sv ====
package cam_pkg;

    ////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////

    // Camera pixel bus
    parameter int pixel_width = 8;
    // System bus data word
    parameter int word_width = 32;
    // Pixels gathered per bus word
    parameter int pixels_per_word = word_width / pixel_width;

    ////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////

    typedef logic [pixel_width-1:0] pixel_t;
    typedef logic [word_width-1:0] word_t;
    // Bit 0 marks first word of a frame, bit 1 first word of a line
    typedef logic [1:0] first_word_t;
    // {href, vsync, pixel}, href on top
    typedef logic [pixel_width+1:0] sample_t;

    // Decoder states
    typedef enum logic [1:0] {wait_frame, frame_blank, line_active} sync_state_t;

endpackage

// ==== source/cam_sample_if.sv ====
`timescale 1ns/1ps

// Camera samples already moved into the system clock domain
interface cam_sample_if;

    // Head sample of the clock-crossing FIFO
    cam_pkg::sample_t sample;
    // No sample available
    logic empty;
    // Consume head on this edge
    logic pop;

    // FIFO side
    modport src (output sample, output empty, input pop);
    // Decoder side
    modport dst (input sample, input empty, output pop);

endinterface

// ==== source/cam_word_if.sv ====
`timescale 1ns/1ps

// Packed words going into the bus-side FIFO
interface cam_word_if;

    // Four pixels, first one in the low byte
    cam_pkg::word_t word;
    // First-of-frame and first-of-line marks
    cam_pkg::first_word_t tag;
    // Write strobe, never raised while full
    logic push;
    // FIFO has no free slot
    logic full;

    // Packer side
    modport src (output word, output tag, output push, input full);
    // FIFO side
    modport dst (input word, input tag, input push, output full);

endinterface

// ==== source/frame_sync_decoder.sv ====
`timescale 1ns/1ps

module frame_sync_decoder (
    input  logic      clk_i,
    input  logic      rst_n_i,
    cam_sample_if.dst sample_i,
    cam_pixel_if.src  pixel_o,
    output logic      irq_new_frame_o
);

    cam_pkg::sync_state_t state;
    cam_pkg::pixel_t      pixel_q;
    logic pop;
    logic href;
    logic vsync;
    // Levels of the previously popped sample
    logic href_prev;
    logic vsync_prev;
    logic pixel_valid_q;
    logic frame_start_q;
    logic line_start_q;

    // Field split of head sample
    assign href  = sample_i.sample[cam_pkg::pixel_width+1];
    assign vsync = sample_i.sample[cam_pkg::pixel_width];

    // Pop whenever data is there and packer not holding a word
    assign pop = !sample_i.empty && !pixel_o.stall;
    assign sample_i.pop = pop;

    ////////////////////////////////////////
    // Edge detect and frame FSM
    ////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state         <= cam_pkg::wait_frame;
            href_prev     <= 1'b0;
            vsync_prev    <= 1'b0;
            pixel_valid_q <= 1'b0;
            frame_start_q <= 1'b0;
            line_start_q  <= 1'b0;
        end else begin
            // Pulses by default
            pixel_valid_q <= 1'b0;
            frame_start_q <= 1'b0;
            line_start_q  <= 1'b0;
            if (pop) begin
                href_prev  <= href;
                vsync_prev <= vsync;
                case (state)
                    // Skip partial frame until vsync falls
                    cam_pkg::wait_frame: begin
                        if (vsync_prev && !vsync) begin
                            frame_start_q <= 1'b1;
                            state         <= cam_pkg::frame_blank;
                        end
                    end
                    cam_pkg::frame_blank: begin
                        if (vsync && !vsync_prev) begin
                            state <= cam_pkg::wait_frame;
                        end else if (href && !href_prev) begin
                            // First pixel of a line
                            line_start_q  <= 1'b1;
                            pixel_valid_q <= 1'b1;
                            state         <= cam_pkg::line_active;
                        end
                    end
                    default: begin
                        if (vsync && !vsync_prev) begin
                            state <= cam_pkg::wait_frame;
                        end else if (href) begin
                            pixel_valid_q <= 1'b1;
                        end else begin
                            // Horizontal blanking
                            state <= cam_pkg::frame_blank;
                        end
                    end
                endcase
            end
        end
    end

    // Pixel byte follows each pop
    always_ff @(posedge clk_i) begin
        if (pop) begin
            pixel_q <= sample_i.sample[cam_pkg::pixel_width-1:0];
        end
    end

    assign pixel_o.pixel       = pixel_q;
    assign pixel_o.pixel_valid = pixel_valid_q;
    assign pixel_o.frame_start = frame_start_q;
    assign pixel_o.line_start  = line_start_q;
    // Interrupt shares the frame start pulse
    assign irq_new_frame_o = frame_start_q;

endmodule

// ==== source/pixel_packer.sv ====
`timescale 1ns/1ps

module pixel_packer (
    input  logic     clk_i,
    input  logic     rst_n_i,
    cam_pixel_if.dst pixel_i,
    cam_word_if.src  word_o
);

    localparam int cnt_width = $clog2(cam_pkg::pixels_per_word);

    typedef logic [cnt_width-1:0] cnt_t;

    cnt_t count;
    cnt_t idx;
    cam_pkg::word_t acc;
    cam_pkg::word_t acc_next;
    cam_pkg::word_t word_q;
    cam_pkg::first_word_t tag_q;
    logic last;
    logic complete;
    // Finished word waiting for the FIFO
    logic ready;
    logic frame_pend;
    logic line_pend;
    logic frame_eff;
    logic line_eff;

    // Line start drops the partial word
    assign idx = pixel_i.line_start ? '0 : count;
    assign last = (idx == cnt_t'(cam_pkg::pixels_per_word - 1));
    assign complete = pixel_i.pixel_valid && last;
    assign frame_eff = frame_pend || pixel_i.frame_start;
    assign line_eff = line_pend || pixel_i.line_start;

    // Lowest byte filled first
    always_comb begin
        acc_next = acc;
        acc_next[idx*cam_pkg::pixel_width +: cam_pkg::pixel_width] = pixel_i.pixel;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count      <= '0;
            ready      <= 1'b0;
            frame_pend <= 1'b0;
            line_pend  <= 1'b0;
        end else begin
            if (word_o.push) begin
                ready <= 1'b0;
            end
            if (complete) begin
                ready      <= 1'b1;
                frame_pend <= 1'b0;
                line_pend  <= 1'b0;
            end else begin
                if (pixel_i.frame_start) frame_pend <= 1'b1;
                if (pixel_i.line_start) line_pend <= 1'b1;
            end
            if (pixel_i.pixel_valid) begin
                count <= last ? '0 : cnt_t'(idx + 1'b1);
            end else if (pixel_i.line_start) begin
                count <= '0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (pixel_i.pixel_valid) acc <= acc_next;
        if (complete) begin
            word_q <= acc_next;
            tag_q  <= {line_eff, frame_eff};
        end
    end

    // Push next cycle, hold and stall while FIFO full
    assign word_o.push = ready && !word_o.full;
    assign word_o.word = word_q;
    assign word_o.tag = tag_q;
    assign pixel_i.stall = ready && word_o.full;

endmodule

// ==== source/word_fifo.sv ====
`timescale 1ns/1ps

module word_fifo #(
    parameter int word_addr_width = 3
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    cam_word_if.dst              word_i,
    input  logic                 wb_stb_i,
    output cam_pkg::word_t       wb_dat_o,
    output cam_pkg::first_word_t out_first_word_o,
    output logic                 wb_ack_o,
    output logic                 wb_rty_o,
    output logic                 buffer_fifo_full_o
);

    localparam int depth = 2 ** word_addr_width;

    // Wrap bit on top of the address
    typedef logic [word_addr_width:0] ptr_t;

    cam_pkg::word_t       word_mem [depth];
    cam_pkg::first_word_t tag_mem [depth];
    ptr_t wr_ptr;
    ptr_t rd_ptr;
    logic empty;
    logic full;
    logic pop;

    ////////////////////////////////////////
    // Pointer compare
    ////////////////////////////////////////

    assign empty = (wr_ptr == rd_ptr);
    // Same slot, different lap
    assign full = (wr_ptr[word_addr_width] != rd_ptr[word_addr_width]) &&
                  (wr_ptr[word_addr_width-1:0] == rd_ptr[word_addr_width-1:0]);
    // Strobe only takes effect while ack is up
    assign pop = wb_stb_i && !empty;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (word_i.push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Word and tag stored side by side
    always_ff @(posedge clk_i) begin
        if (word_i.push) begin
            word_mem[wr_ptr[word_addr_width-1:0]] <= word_i.word;
            tag_mem[wr_ptr[word_addr_width-1:0]]  <= word_i.tag;
        end
    end

    ////////////////////////////////////////
    // Bus side
    ////////////////////////////////////////

    // Head of the queue
    assign wb_dat_o = word_mem[rd_ptr[word_addr_width-1:0]];
    assign out_first_word_o = tag_mem[rd_ptr[word_addr_width-1:0]];
    // Ack level while data is there, retry otherwise
    assign wb_ack_o = !empty;
    assign wb_rty_o = empty;
    assign buffer_fifo_full_o = full;
    assign word_i.full = full;

endmodule

// ==== testbench/tb_cam_data_module.sv ====
`timescale 1ns/1ps

module tb_cam_data_module;

    localparam int clk_period = 100;
    localparam int pclk_period = 230;
    localparam int frame_count = 6;
    // Reader modes
    localparam int read_always = 0;
    localparam int read_gaps = 1;
    localparam int read_pause = 2;
    // Cycles the reader stays stopped after the FIFO reports full
    localparam int pause_hold = 6;

    ////////////////////////////////////////
    // Frame table
    ////////////////////////////////////////

    // Lines, pixels per line, line blanking, vsync blanking, reader mode
    int lines_tab [frame_count] = '{3, 4, 6, 2, 5, 4};
    int pixels_tab [frame_count] = '{8, 13, 16, 6, 10, 20};
    int hblank_tab [frame_count] = '{3, 2, 4, 3, 2, 3};
    int vblank_tab [frame_count] = '{4, 5, 3, 4, 6, 4};
    int mode_tab [frame_count] = '{read_always, read_gaps, read_pause,
                                   read_always, read_gaps, read_pause};

    logic clk_i;
    logic pclk_i;
    logic rst_n_i;
    logic wb_stb_i;
    logic vsync_i;
    logic href_i;
    cam_pkg::pixel_t d_i;
    cam_pkg::word_t wb_dat_o;
    cam_pkg::first_word_t out_first_word_o;
    logic wb_ack_o;
    logic wb_rty_o;
    logic irq_new_frame_o;
    logic buffer_fifo_full_o;

    // Expected words in camera order, with tag and frame index
    cam_pkg::word_t exp_words [$];
    cam_pkg::first_word_t exp_tags [$];
    int exp_frames [$];
    bit pause_done [frame_count];
    int irq_count;
    bit camera_done;
    logic [31:0] cam_lfsr;
    logic [31:0] gap_lfsr;

    cam_data_module #(
        .cdc_addr_width(4),
        .word_addr_width(3)
    ) cam_data_module_i (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .wb_stb_i(wb_stb_i),
        .pclk_i(pclk_i), .vsync_i(vsync_i), .href_i(href_i), .d_i(d_i),
        .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .wb_rty_o(wb_rty_o),
        .irq_new_frame_o(irq_new_frame_o), .buffer_fifo_full_o(buffer_fifo_full_o),
        .out_first_word_o(out_first_word_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(clk_period / 2) clk_i = ~clk_i;
    end

    // Camera clock, unrelated to clk_i
    initial begin
        pclk_i = 1'b0;
        forever #(pclk_period / 2) pclk_i = ~pclk_i;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic next_pixel(output cam_pkg::pixel_t pix);
        pix = '0;
        repeat (cam_pkg::pixel_width) begin
            cam_lfsr = lfsr_next(cam_lfsr);
            pix = {pix[cam_pkg::pixel_width-2:0], cam_lfsr[0]};
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_word(input string name, input cam_pkg::word_t got,
                              input cam_pkg::word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_tag(input string name, input cam_pkg::first_word_t got,
                             input cam_pkg::first_word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    ////////////////////////////////////////
    // Camera driver and reference model
    ////////////////////////////////////////

    task automatic blank_cycles(input logic vs, input int n);
        repeat (n) begin
            @(posedge pclk_i);
            vsync_i <= vs;
            href_i  <= 1'b0;
            d_i     <= '0;
        end
    endtask

    // One href line; keep low means the line is never expected at the bus
    task automatic send_line(input int npix, input bit first_line, input int frame,
                             input bit keep);
        cam_pkg::pixel_t pix;
        cam_pkg::word_t word;
        cam_pkg::first_word_t tag;
        int slot;
        int i;
        word = '0;
        for (i = 0; i < npix; i++) begin
            next_pixel(pix);
            slot = i % cam_pkg::pixels_per_word;
            @(posedge pclk_i);
            vsync_i <= 1'b0;
            href_i  <= 1'b1;
            d_i     <= pix;
            // First pixel in the low byte
            word[slot*cam_pkg::pixel_width +: cam_pkg::pixel_width] = pix;
            if (keep && slot == cam_pkg::pixels_per_word - 1) begin
                // Only the first word of a line carries a tag
                if (i == cam_pkg::pixels_per_word - 1) begin
                    tag = first_line ? 2'b11 : 2'b10;
                end else begin
                    tag = 2'b00;
                end
                exp_words.push_back(word);
                exp_tags.push_back(tag);
                exp_frames.push_back(frame);
            end
        end
    endtask

    initial begin
        int f;
        int l;
        wait (rst_n_i);
        blank_cycles(1'b0, 3);
        // Frame already running at start, no vsync fall seen
        for (l = 0; l < 2; l++) begin
            send_line(7, 1'b0, 0, 1'b0);
            blank_cycles(1'b0, 3);
        end
        for (f = 0; f < frame_count; f++) begin
            blank_cycles(1'b1, vblank_tab[f]);
            blank_cycles(1'b0, hblank_tab[f]);
            for (l = 0; l < lines_tab[f]; l++) begin
                send_line(pixels_tab[f], l == 0, f, 1'b1);
                blank_cycles(1'b0, hblank_tab[f]);
            end
        end
        // Park in vertical blanking
        blank_cycles(1'b1, 4);
        camera_done = 1'b1;
    end

    ////////////////////////////////////////
    // Bus reader
    ////////////////////////////////////////

    initial begin
        int head;
        int hold;
        logic [1:0] gap_bits;
        hold = 0;
        gap_bits = '0;
        wait (rst_n_i);
        forever begin
            @(posedge clk_i);
            if (irq_new_frame_o) irq_count++;
            if (wb_stb_i && wb_ack_o) begin
                if (exp_words.size() == 0) begin
                    abort_run("A word was delivered although no word was expected");
                end
                check_word("wb_dat_o", wb_dat_o, exp_words.pop_front());
                check_tag("out_first_word_o", out_first_word_o, exp_tags.pop_front());
                void'(exp_frames.pop_front());
            end else if (exp_words.size() == 0) begin
                // Nothing owed, bus must answer retry
                check_level("wb_rty_o", wb_rty_o, 1'b1);
            end
            head = (exp_frames.size() != 0) ? exp_frames[0] : -1;
            if (head >= 0 && mode_tab[head] == read_pause && !pause_done[head]) begin
                wb_stb_i <= 1'b0;
                if (wb_ack_o) check_level("wb_rty_o", wb_rty_o, 1'b0);
                if (buffer_fifo_full_o || hold != 0) hold++;
                if (hold >= pause_hold) begin
                    pause_done[head] = 1'b1;
                    hold = 0;
                    wb_stb_i <= 1'b1;
                end
            end else if (head >= 0 && mode_tab[head] == read_gaps) begin
                gap_lfsr = lfsr_next(gap_lfsr);
                gap_bits[0] = gap_lfsr[0];
                gap_lfsr = lfsr_next(gap_lfsr);
                gap_bits[1] = gap_lfsr[0];
                // Strobe on three cycles out of four
                wb_stb_i <= |gap_bits;
            end else begin
                wb_stb_i <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Watchdog
    ////////////////////////////////////////

    initial begin
        int total;
        int f;
        // Leading idle, partial frame and trailing blanking in pclk cycles
        total = 3 + 2 * (7 + 3) + 4;
        for (f = 0; f < frame_count; f++) begin
            total += lines_tab[f] * (pixels_tab[f] + hblank_tab[f]);
            total += vblank_tab[f] + hblank_tab[f];
        end
        #((total * pclk_period + 10 * clk_period) * 2);
        abort_run("The run timed out before all expected words were read");
    end

    ////////////////////////////////////////
    // Reset and final checks
    ////////////////////////////////////////

    initial begin
        rst_n_i     = 1'b0;
        wb_stb_i    = 1'b0;
        vsync_i     = 1'b0;
        href_i      = 1'b0;
        d_i         = '0;
        irq_count   = 0;
        camera_done = 1'b0;
        cam_lfsr    = 32'hcba7ae6c;
        gap_lfsr    = 32'hcba7ae6c;
        for (int f = 0; f < frame_count; f++) begin
            pause_done[f] = 1'b0;
        end
        repeat (10) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        check_level("wb_ack_o", wb_ack_o, 1'b0);
        check_level("wb_rty_o", wb_rty_o, 1'b1);
        check_level("irq_new_frame_o", irq_new_frame_o, 1'b0);
        check_level("buffer_fifo_full_o", buffer_fifo_full_o, 1'b0);
        wait (camera_done);
        while (exp_words.size() != 0) @(posedge clk_i);
        // Room for stray words or pulses
        repeat (20) @(posedge clk_i);
        @(negedge clk_i);
        check_count("irq_new_frame_o pulses", irq_count, frame_count);
        check_level("wb_rty_o", wb_rty_o, 1'b1);
        check_level("buffer_fifo_full_o", buffer_fifo_full_o, 1'b0);
        $display("RESULT: PASS");
        $finish;
    end

endmodule
